// ==== common/flight_pkg.sv ====
// flight_pkg: rate and motor types, axis-rate, scaler, motor-rate and mixer config structs
package flight_pkg;

  // ##########################################################################
  // rate widths and scalar types
  // ##########################################################################
  localparam int RATE_W     = 16;          // all axis rates and motor commands
  localparam int SHIFT_W    = 4;           // power-of-two scaler field
  localparam int NUM_MOTORS = 4;           // X-frame

  typedef logic signed [RATE_W-1:0] rate_t;        // fixed point, two's complement
  typedef logic        [RATE_W-1:0] motor_rate_t;  // unsigned motor command
  typedef logic        [SHIFT_W-1:0] shift_t;

  // one control step worth of axis rates
  typedef struct packed {
    rate_t throttle;
    rate_t yaw;
    rate_t roll;
    rate_t pitch;
  } axis_rates_t;                          // 64 bits

  // arithmetic right shift per axis, stands in for a multiplier
  typedef struct packed {
    shift_t yaw_shift;
    shift_t roll_shift;
    shift_t pitch_shift;
  } scalers_t;                             // 12 bits

  // index 0 front-left, then clockwise
  typedef motor_rate_t [NUM_MOTORS-1:0] motor_rates_t;

  // run-time mixer setup from the register block
  typedef struct packed {
    motor_rate_t bias;
    scalers_t    scalers;
    logic        armed;
  } mixer_cfg_t;                           // 29 bits

  // halve every axis out of reset
  localparam scalers_t SCALERS_RESET = '{
    yaw_shift:   SHIFT_W'(1),
    roll_shift:  SHIFT_W'(1),
    pitch_shift: SHIFT_W'(1)
  };

endpackage

// ==== common/bus_pkg.sv ====
// bus_pkg: Wishbone request/response structs, register map offsets and ID constant
package bus_pkg;

  localparam int WB_ADR_W = 4;             // word address
  localparam int WB_DAT_W = 32;
  localparam int WB_SEL_W = WB_DAT_W / 8;  // one sel bit per byte lane

  typedef logic [WB_ADR_W-1:0] wb_adr_t;

  // master to slave
  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    wb_adr_t             adr;
    logic [WB_DAT_W-1:0] dat;
    logic [WB_SEL_W-1:0] sel;
  } wb_req_t;

  // slave to master
  typedef struct packed {
    logic                ack;
    logic [WB_DAT_W-1:0] dat;
  } wb_rsp_t;

  // ##########################################################################
  // register map, word offsets
  // ##########################################################################
  localparam wb_adr_t REG_BIAS    = 4'd0;  // motor bias, bits 15..0
  localparam wb_adr_t REG_SCALERS = 4'd1;  // yaw 3..0, roll 7..4, pitch 11..8
  localparam wb_adr_t REG_CTRL    = 4'd2;  // bit 0 arm
  localparam wb_adr_t REG_ID      = 4'd3;  // read only

  localparam logic [WB_DAT_W-1:0] MIXER_ID = 32'h4d495831;  // "MIX1"

endpackage

// ==== hw/mixer/motor_rate_calculator.sv ====
// motor_rate_calculator: one motor's signed shift-and-sum with saturation, registered
`timescale 1ns/1ps

module motor_rate_calculator
  import flight_pkg::*;
#(
  parameter bit YAW_NEG   = 1'b0,  // subtract the yaw term on this motor
  parameter bit ROLL_NEG  = 1'b0,
  parameter bit PITCH_NEG = 1'b0
) (
  input  logic        sys_clk,
  input  logic        rst_n,
  input  logic        valid,
  input  axis_rates_t rates,
  input  motor_rate_t bias,
  input  scalers_t    scalers,
  output motor_rate_t motor_rate
);

  // 4 guard bits cover bias + throttle + three full-scale terms
  localparam int SUM_W = RATE_W + 4;
  typedef logic signed [SUM_W-1:0] sum_t;
  localparam sum_t MAX_RATE = sum_t'(2**RATE_W - 1);

  rate_t yaw_shifted;
  rate_t roll_shifted;
  rate_t pitch_shifted;
  sum_t  yaw_term;
  sum_t  roll_term;
  sum_t  pitch_term;
  sum_t  base_term;
  sum_t  sum;
  sum_t  sat;

  // ##########################################################################
  // scale, sign, sum
  // ##########################################################################
  always_comb begin
    yaw_shifted   = $signed(rates.yaw)   >>> scalers.yaw_shift;    // sign kept
    roll_shifted  = $signed(rates.roll)  >>> scalers.roll_shift;
    pitch_shifted = $signed(rates.pitch) >>> scalers.pitch_shift;

    yaw_term   = YAW_NEG   ? -sum_t'(yaw_shifted)   : sum_t'(yaw_shifted);
    roll_term  = ROLL_NEG  ? -sum_t'(roll_shifted)  : sum_t'(roll_shifted);
    pitch_term = PITCH_NEG ? -sum_t'(pitch_shifted) : sum_t'(pitch_shifted);

    // bias zero extended, throttle sign extended
    base_term = sum_t'({1'b0, bias}) + sum_t'(rates.throttle);
    sum       = base_term + yaw_term + roll_term + pitch_term;

    // clamp into the unsigned motor range
    if (sum < 0) begin
      sat = '0;
    end else if (sum > MAX_RATE) begin
      sat = MAX_RATE;
    end else begin
      sat = sum;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      motor_rate <= '0;
    end else if (valid) begin
      motor_rate <= sat[RATE_W-1:0];  // hold between samples
    end
  end

  // saturated value fits 16 bits unsigned
  assert property (@(posedge sys_clk) disable iff (!rst_n)
    valid |-> (sat >= 0) && (sat <= MAX_RATE));

endmodule

// ==== hw/mixer/motor_mixer.sv ====
// motor_mixer: four motor rate calculators, X-frame sign table, arm gating, output valid
`timescale 1ns/1ps

module motor_mixer
  import flight_pkg::*;
(
  input  logic         sys_clk,
  input  logic         rst_n,
  input  logic         rates_valid,
  input  axis_rates_t  rates,
  input  mixer_cfg_t   cfg,
  output motor_rates_t motor_rates,
  output logic         motor_valid
);

  // ##########################################################################
  // X-frame sign table, bit i = motor i, 1 = term subtracted
  //   0 front-left   1 front-right   2 rear-right   3 rear-left
  // ##########################################################################
  localparam logic [NUM_MOTORS-1:0] YAW_NEG_TBL   = 4'b0101;  // motors 0 and 2 spin cw
  localparam logic [NUM_MOTORS-1:0] ROLL_NEG_TBL  = 4'b0110;  // right side
  localparam logic [NUM_MOTORS-1:0] PITCH_NEG_TBL = 4'b1100;  // rear pair

  motor_rates_t raw_rates;  // calculator outputs before arm gate
  logic         armed_q;    // arm state captured with the sample

  for (genvar m = 0; m < NUM_MOTORS; m++) begin : g_motor
    motor_rate_calculator #(
      .YAW_NEG   (YAW_NEG_TBL[m]),
      .ROLL_NEG  (ROLL_NEG_TBL[m]),
      .PITCH_NEG (PITCH_NEG_TBL[m])
    ) i_motor_rate_calculator (
      .sys_clk    (sys_clk),
      .rst_n      (rst_n),
      .valid      (rates_valid),
      .rates      (rates),
      .bias       (cfg.bias),
      .scalers    (cfg.scalers),
      .motor_rate (raw_rates[m])
    );
  end

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      motor_valid <= 1'b0;
      armed_q     <= 1'b0;  // disarmed out of reset
    end else begin
      motor_valid <= rates_valid;  // one stage, matches calculators
      if (rates_valid) begin
        armed_q <= cfg.armed;
      end
    end
  end

  // disarmed -> all motors stopped
  assign motor_rates = armed_q ? raw_rates : '0;

  // first cycle out of reset never carries a result
  assert property (@(posedge sys_clk) $rose(rst_n) |-> !motor_valid);

endmodule

// ==== hw/mixer_regs.sv ====
// mixer_regs: Wishbone classic slave with bias, scaler, control and ID registers
`timescale 1ns/1ps

module mixer_regs
  import flight_pkg::*;
  import bus_pkg::*;
(
  input  logic       sys_clk,
  input  logic       rst_n,
  input  wb_req_t    wb_req,
  output wb_rsp_t    wb_rsp,
  output mixer_cfg_t cfg
);

  logic                req_seen;  // new request this cycle
  logic                wr_en;
  logic [WB_DAT_W-1:0] rd_data;

  // ack low gate keeps each request to a single ack
  assign req_seen = wb_req.cyc && wb_req.stb && !wb_rsp.ack;
  assign wr_en    = req_seen && wb_req.we;

  // ##########################################################################
  // read mux
  // ##########################################################################
  always_comb begin
    rd_data = '0;  // unmapped words read zero
    case (wb_req.adr)
      REG_BIAS:    rd_data = WB_DAT_W'(cfg.bias);
      REG_SCALERS: rd_data = WB_DAT_W'({cfg.scalers.pitch_shift,
                                        cfg.scalers.roll_shift,
                                        cfg.scalers.yaw_shift});
      REG_CTRL:    rd_data = WB_DAT_W'(cfg.armed);
      REG_ID:      rd_data = MIXER_ID;
      default:     rd_data = '0;
    endcase
  end

  // ##########################################################################
  // register writes, byte lanes honored
  // ##########################################################################
  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      cfg.bias    <= '0;
      cfg.scalers <= SCALERS_RESET;  // every axis halved
      cfg.armed   <= 1'b0;
    end else if (wr_en) begin
      case (wb_req.adr)
        REG_BIAS: begin
          if (wb_req.sel[0]) cfg.bias[7:0]  <= wb_req.dat[7:0];
          if (wb_req.sel[1]) cfg.bias[15:8] <= wb_req.dat[15:8];
        end
        REG_SCALERS: begin
          if (wb_req.sel[0]) begin
            cfg.scalers.yaw_shift  <= wb_req.dat[3:0];
            cfg.scalers.roll_shift <= wb_req.dat[7:4];
          end
          if (wb_req.sel[1]) cfg.scalers.pitch_shift <= wb_req.dat[11:8];
        end
        REG_CTRL: begin
          if (wb_req.sel[0]) cfg.armed <= wb_req.dat[0];
        end
        default: ;  // ID and unmapped words ignore writes
      endcase
    end
  end

  // ack one edge after the request
  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      wb_rsp.ack <= 1'b0;
    end else begin
      wb_rsp.ack <= req_seen;
    end
  end

  // read data goes out with ack
  always_ff @(posedge sys_clk) begin
    if (req_seen) begin
      wb_rsp.dat <= rd_data;
    end
  end

  // single-cycle ack, and only in answer to cyc and stb
  assert property (@(posedge sys_clk) disable iff (!rst_n)
    wb_rsp.ack |=> !wb_rsp.ack);
  assert property (@(posedge sys_clk) disable iff (!rst_n)
    wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb));

endmodule

// ==== hw/pwm_generator.sv ====
// pwm_generator: four PWM channels on one shared period counter, duty latched at wrap
`timescale 1ns/1ps

module pwm_generator
  import flight_pkg::*;
#(
  parameter int PWM_BITS = 8  // period is 2**PWM_BITS cycles
) (
  input  logic                  sys_clk,
  input  logic                  rst_n,
  input  motor_rates_t          motor_rates,
  output logic [NUM_MOTORS-1:0] pwm
);

  logic [PWM_BITS-1:0] cnt;                     // free running
  logic [PWM_BITS-1:0] duty [NUM_MOTORS];       // one per channel
  logic                wrap;                    // last count of the period

  assign wrap = (cnt == '1);

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;  // rolls over to zero on its own
    end
  end

  // ##########################################################################
  // duty update, takes effect as the counter restarts at zero
  // ##########################################################################
  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      for (int m = 0; m < NUM_MOTORS; m++) begin
        duty[m] <= '0;
      end
    end else if (wrap) begin
      for (int m = 0; m < NUM_MOTORS; m++) begin
        duty[m] <= motor_rates[m][RATE_W-1 -: PWM_BITS];  // top bits of rate
      end
    end
  end

  // high while below duty; zero stays low, full scale misses one cycle
  always_comb begin
    for (int m = 0; m < NUM_MOTORS; m++) begin
      pwm[m] = (cnt < duty[m]);
    end
  end

endmodule

// ==== hw/flight_mixer_top.sv ====
// flight_mixer_top: register block, motor mixer and PWM generator
`timescale 1ns/1ps

module flight_mixer_top
  import flight_pkg::*;
  import bus_pkg::*;
#(
  parameter int PWM_BITS = 8
) (
  input  logic                  sys_clk,
  input  logic                  rst_n,
  input  wb_req_t               wb_req,
  output wb_rsp_t               wb_rsp,
  input  logic                  rates_valid,
  input  axis_rates_t           rates,
  output motor_rates_t          motor_rates,
  output logic                  motor_valid,
  output logic [NUM_MOTORS-1:0] pwm
);

  mixer_cfg_t cfg;  // bias, scalers, arm

  mixer_regs i_mixer_regs (
    .sys_clk (sys_clk),
    .rst_n   (rst_n),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp),
    .cfg     (cfg)
  );

  motor_mixer i_motor_mixer (
    .sys_clk     (sys_clk),
    .rst_n       (rst_n),
    .rates_valid (rates_valid),
    .rates       (rates),
    .cfg         (cfg),
    .motor_rates (motor_rates),
    .motor_valid (motor_valid)
  );

  // PWM follows the gated motor rates
  pwm_generator #(
    .PWM_BITS (PWM_BITS)
  ) i_pwm_generator (
    .sys_clk     (sys_clk),
    .rst_n       (rst_n),
    .motor_rates (motor_rates),
    .pwm         (pwm)
  );

endmodule

// ==== verification/tb_clock_gen.sv ====
// tb_clock_gen: testbench clock and synchronous reset generator
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,  // sys_clk period
  parameter int RESET_CYCLES = 16,  // rising edges with rst_n low
  parameter int DRIVE_DELAY  = 2    // skew after the edge
) (
  output logic sys_clk,
  output logic rst_n
);

  initial begin
    sys_clk = 1'b0;
    forever #(PERIOD_NS / 2) sys_clk = ~sys_clk;
  end

  initial begin
    rst_n = 1'b0;                           // held from time zero
    repeat (RESET_CYCLES) @(posedge sys_clk);
    #(DRIVE_DELAY) rst_n = 1'b1;            // released off the edge
  end

endmodule

// ==== verification/tb_flight_mixer.sv ====
// tb_flight_mixer: directed tests, reference model, checker, watchdog and summary
`timescale 1ns/1ps

module tb_flight_mixer
  import flight_pkg::*;
  import bus_pkg::*;
();

  localparam int CLK_NS    = 40;
  localparam int DRV_NS    = 2;             // input skew after the rising edge
  localparam int PWM_BITS  = 8;
  localparam int PWM_LEN   = 1 << PWM_BITS;
  localparam int ACK_LIMIT = 16;            // cycles a wishbone access may take
  // rough cycle budget per test, plus reset and margin
  localparam int RUN_CYCLES = 16 + 80 + 40 + 200 + 60 + (3 * PWM_LEN) + 200;

  logic         sys_clk;
  logic         rst_n;
  wb_req_t      wb_req;
  wb_rsp_t      wb_rsp;
  logic         rates_valid;
  axis_rates_t  rates;
  motor_rates_t motor_rates;
  logic         motor_valid;
  logic [3:0]   pwm;

  // model of the programmed configuration
  logic [15:0]  bias_m;
  logic [3:0]   yaw_sh_m;
  logic [3:0]   roll_sh_m;
  logic [3:0]   pitch_sh_m;
  logic         armed_m;

  // X-frame signs per motor, front-left then clockwise
  int yaw_sign   [4] = '{-1, 1, -1, 1};
  int roll_sign  [4] = '{1, -1, -1, 1};
  int pitch_sign [4] = '{1, 1, -1, -1};

  logic [31:0]  lfsr_state = 32'hf7084ffc;
  int           errors = 0;
  int           checks = 0;
  int           tests_run = 0;

  tb_clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(16), .DRIVE_DELAY(DRV_NS)) i_tb_clock_gen (
    .sys_clk (sys_clk),
    .rst_n   (rst_n)
  );

  flight_mixer_top #(.PWM_BITS(PWM_BITS)) i_flight_mixer_top (
    .sys_clk     (sys_clk),
    .rst_n       (rst_n),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .rates_valid (rates_valid),
    .rates       (rates),
    .motor_rates (motor_rates),
    .motor_valid (motor_valid),
    .pwm         (pwm)
  );

  // ##########################################################################
  // helpers
  // ##########################################################################
  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // x^32+x^22+x^2+x+1
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};  // one step per bit
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic axis_rates_t make_rates(input logic [15:0] t, input logic [15:0] y,
                                             input logic [15:0] r, input logic [15:0] p);
    axis_rates_t s;
    s.throttle = t;
    s.yaw      = y;
    s.roll     = r;
    s.pitch    = p;
    return s;
  endfunction

  task automatic random_rates(output axis_rates_t s);
    logic [31:0] t;
    logic [31:0] y;
    logic [31:0] r;
    logic [31:0] p;
    draw_bits(16, t);
    draw_bits(16, y);
    draw_bits(16, r);
    draw_bits(16, p);
    s = make_rates(t[15:0], y[15:0], r[15:0], p[15:0]);
  endtask

  // mixing rule: bias + throttle + signed, shifted axis terms, clamped
  task automatic compute_expected(input axis_rates_t s, output motor_rates_t exp);
    int sum;
    for (int m = 0; m < 4; m++) begin
      sum = int'(bias_m) + int'(s.throttle);
      sum += yaw_sign[m]   * (int'(s.yaw)   >>> yaw_sh_m);
      sum += roll_sign[m]  * (int'(s.roll)  >>> roll_sh_m);
      sum += pitch_sign[m] * (int'(s.pitch) >>> pitch_sh_m);
      if (sum < 0) sum = 0;
      if (sum > 65535) sum = 65535;
      exp[m] = armed_m ? 16'(sum) : 16'h0;  // disarmed motors stop
    end
  endtask

  task automatic wb_access(input logic we, input wb_adr_t adr, input logic [31:0] wdat,
                           input logic [3:0] sel, output logic [31:0] rdat);
    int waited;
    waited = 0;
    @(posedge sys_clk);
    #(DRV_NS);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    wb_req.sel = sel;
    while (!wb_rsp.ack && waited < ACK_LIMIT) begin  // held until ack
      @(posedge sys_clk);
      #(DRV_NS);
      waited++;
    end
    if (!wb_rsp.ack) begin
      errors++;
      $display("wishbone access to word %0d got no ack within %0d cycles", adr, ACK_LIMIT);
    end
    rdat   = wb_rsp.dat;
    wb_req = '0;
  endtask

  task automatic wb_write(input wb_adr_t adr, input logic [31:0] dat, input logic [3:0] sel);
    logic [31:0] unused;
    wb_access(1'b1, adr, dat, sel, unused);
  endtask

  task automatic read_check(input wb_adr_t adr, input logic [31:0] expected, input string what);
    logic [31:0] dat;
    wb_access(1'b0, adr, 32'h0, 4'hf, dat);
    check_equal(dat, expected, what);
  endtask

  task automatic set_config(input logic [15:0] bias, input logic [3:0] ysh,
                            input logic [3:0] rsh, input logic [3:0] psh, input logic arm);
    wb_write(REG_BIAS, {16'h0, bias}, 4'hf);
    wb_write(REG_SCALERS, {20'h0, psh, rsh, ysh}, 4'hf);
    wb_write(REG_CTRL, {31'h0, arm}, 4'hf);
    bias_m     = bias;
    yaw_sh_m   = ysh;
    roll_sh_m  = rsh;
    pitch_sh_m = psh;
    armed_m    = arm;
  endtask

  task automatic check_motors(input motor_rates_t exp);
    check_equal(motor_valid, 1'b1, "motor_valid");
    for (int m = 0; m < 4; m++) begin
      check_equal(motor_rates[m], exp[m], $sformatf("motor %0d rate", m));
    end
  endtask

  // back-to-back samples, each output checked one cycle after its input
  task automatic send_stream(input int n);
    axis_rates_t  s;
    motor_rates_t prev_exp;
    for (int i = 0; i <= n; i++) begin
      @(posedge sys_clk);
      #(DRV_NS);
      if (i > 0) check_motors(prev_exp);
      if (i < n) begin
        random_rates(s);
        rates       = s;
        rates_valid = 1'b1;
        compute_expected(s, prev_exp);  // config on the accepting edge
      end else begin
        rates_valid = 1'b0;
      end
    end
    @(posedge sys_clk);
    #(DRV_NS);
    check_equal(motor_valid, 1'b0, "motor_valid after stream");
  endtask

  task automatic send_one(input axis_rates_t s, output motor_rates_t exp);
    @(posedge sys_clk);
    #(DRV_NS);
    rates       = s;
    rates_valid = 1'b1;
    compute_expected(s, exp);
    @(posedge sys_clk);
    #(DRV_NS);
    rates_valid = 1'b0;
    check_motors(exp);
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) $display("test %-16s ok", name);
    else $display("test %-16s %0d errors", name, errors - errs_before);
  endtask

  // ##########################################################################
  // tests
  // ##########################################################################
  task automatic test_registers();
    int e0;
    e0 = errors;
    read_check(REG_BIAS, 32'h0, "bias after reset");
    read_check(REG_SCALERS, 32'h111, "scalers after reset");  // all halve
    read_check(REG_CTRL, 32'h0, "ctrl after reset");
    read_check(REG_ID, 32'h4d495831, "id");
    wb_write(REG_BIAS, 32'h0000beef, 4'hf);
    read_check(REG_BIAS, 32'h0000beef, "bias readback");
    wb_write(REG_SCALERS, 32'h00000a53, 4'hf);
    read_check(REG_SCALERS, 32'h00000a53, "scalers readback");
    wb_write(REG_SCALERS, 32'h00000c21, 4'b0010);  // pitch lane only
    read_check(REG_SCALERS, 32'h00000c53, "scalers byte 1 write");
    wb_write(REG_SCALERS, 32'h00000e76, 4'b0001);  // yaw and roll lane
    read_check(REG_SCALERS, 32'h00000c76, "scalers byte 0 write");
    wb_write(REG_CTRL, 32'h1, 4'hf);
    read_check(REG_CTRL, 32'h1, "ctrl readback");
    wb_write(4'd9, 32'hffffffff, 4'hf);
    read_check(4'd9, 32'h0, "unmapped word");
    wb_write(REG_ID, 32'h0, 4'hf);
    read_check(REG_ID, 32'h4d495831, "id after write");
    set_config(16'h0, 4'd1, 4'd1, 4'd1, 1'b0);  // back to reset values
    finish_test("registers", e0);
  endtask

  task automatic test_disarmed();
    int e0;
    e0 = errors;
    set_config(16'h3000, 4'd0, 4'd1, 4'd2, 1'b0);
    check_equal(motor_valid, 1'b0, "motor_valid idle");
    send_stream(8);
    finish_test("disarmed", e0);
  endtask

  task automatic test_mixing();
    int e0;
    e0 = errors;
    set_config(16'h0, 4'd1, 4'd1, 4'd1, 1'b1);
    send_stream(40);
    set_config(16'h2000, 4'd0, 4'd2, 4'd3, 1'b1);
    send_stream(40);
    set_config(16'h8000, 4'd15, 4'd7, 4'd0, 1'b1);
    send_stream(40);
    finish_test("mixing", e0);
  endtask

  task automatic test_saturation();
    int           e0;
    motor_rates_t exp;
    e0 = errors;
    set_config(16'hf000, 4'd0, 4'd0, 4'd0, 1'b1);
    send_one(make_rates(16'h7fff, 16'h4000, 16'h4000, 16'h4000), exp);
    check_equal(motor_rates[0], 16'hffff, "front-left clamp high");  // +roll +pitch
    set_config(16'h0000, 4'd0, 4'd0, 4'd0, 1'b1);
    send_one(make_rates(16'h0100, 16'h4000, 16'h4000, 16'h4000), exp);
    check_equal(motor_rates[2], 16'h0, "rear-right clamp low");      // all terms negated
    finish_test("saturation", e0);
  endtask

  task automatic test_pwm();
    int           e0;
    int           high_cnt [4];
    motor_rates_t exp;
    e0 = errors;
    set_config(16'h7000, 4'd0, 4'd0, 4'd0, 1'b1);
    send_one(make_rates(16'h4000, 16'h0000, 16'h3000, 16'h2000), exp);
    repeat (PWM_LEN + 2) @(posedge sys_clk);  // at least one wrap latches duty
    #(DRV_NS);
    for (int m = 0; m < 4; m++) high_cnt[m] = 0;
    for (int c = 0; c < PWM_LEN; c++) begin  // one whole period
      for (int m = 0; m < 4; m++) high_cnt[m] += pwm[m];
      @(posedge sys_clk);
      #(DRV_NS);
    end
    for (int m = 0; m < 4; m++) begin
      check_equal(high_cnt[m], exp[m] >> (16 - PWM_BITS), $sformatf("pwm %0d high cycles", m));
    end
    finish_test("pwm duty", e0);
  endtask

  // ##########################################################################
  // main sequence and watchdog
  // ##########################################################################
  initial begin
    wb_req      = '0;
    rates_valid = 1'b0;
    rates       = '0;
    bias_m      = '0;
    yaw_sh_m    = 4'd1;
    roll_sh_m   = 4'd1;
    pitch_sh_m  = 4'd1;
    armed_m     = 1'b0;
    wait (rst_n === 1'b1);
    test_registers();
    test_disarmed();
    test_mixing();
    test_saturation();
    test_pwm();
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    #(RUN_CYCLES * CLK_NS);
    $display("the run timed out after %0d cycles before all tests finished", RUN_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== build.f ====
common/flight_pkg.sv
common/bus_pkg.sv
hw/mixer/motor_rate_calculator.sv
hw/mixer/motor_mixer.sv
hw/mixer_regs.sv
hw/pwm_generator.sv
hw/flight_mixer_top.sv
verification/tb_clock_gen.sv
verification/tb_flight_mixer.sv

// ==== Bender.yml ====
package:
  name: flight_mixer

sources:
  - common/flight_pkg.sv
  - common/bus_pkg.sv
  - hw/mixer/motor_rate_calculator.sv
  - hw/mixer/motor_mixer.sv
  - hw/mixer_regs.sv
  - hw/pwm_generator.sv
  - hw/flight_mixer_top.sv
  - target: simulation
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_flight_mixer.sv
